// File: rtl/componentCount_defines.svh
`ifndef COMPONENT_COUNT_DEFINES_SVH
`define COMPONENT_COUNT_DEFINES_SVH

// bits per occupancy graph and link mask
`define GRAPH_WIDTH 128

// count wraps modulo 128
`define COUNT_WIDTH 7

`define TAG_WIDTH 8

`endif

// File: rtl/graphPkg.sv
`include "componentCount_defines.svh"

package graphPkg;

    // one bit per graph position, also used for link masks and component masks
    typedef logic [`GRAPH_WIDTH-1:0] graphVector;

    // result of the lowest-set-bit search
    typedef struct packed {
        // one-hot lowest set bit, zero when nothing is left
        graphVector seed;
        logic       empty;
    } seedInfo;

endpackage

// File: rtl/jobPkg.sv
`include "componentCount_defines.svh"

package jobPkg;

    typedef logic [`COUNT_WIDTH-1:0] countValue;
    typedef logic [`TAG_WIDTH-1:0]   jobTag;

    // one job as it arrives on the intake channel
    typedef struct packed {
        graphPkg::graphVector graph;
        graphPkg::graphVector linkMask;
        countValue            countBase;
        jobTag                tag;
    } jobRequest;

    typedef struct packed {
        countValue count;
        jobTag     tag;
    } jobResult;

endpackage

// File: rtl/seedSelector.sv
`include "componentCount_defines.svh"

module seedSelector (
    input  graphPkg::graphVector leftover,
    output graphPkg::seedInfo    seedInfo
);
    import graphPkg::*;

    // any set bit per 4, 16 and 64 bit group
    logic [31:0] hasBit4;
    logic [7:0]  hasBit16;
    logic [1:0]  hasBit64;

    // first-bit flags, each relative to the next group up
    graphVector  firstBit1;
    logic [31:0] firstBit4;
    logic [7:0]  firstBit16;
    logic [1:0]  firstBit64;

    graphVector  seedVec;

    // lowest set flag among four, by prefix priority
    function automatic logic [3:0] firstOfFour(input logic [3:0] has);
        firstOfFour[0] = has[0];
        firstOfFour[1] = has[1] & ~has[0];
        firstOfFour[2] = has[2] & ~(|has[1:0]);
        firstOfFour[3] = has[3] & ~(|has[2:0]);
    endfunction

    for (genvar i = 0; i < 32; i++) begin : gLevel4
        assign hasBit4[i]          = |leftover[4*i +: 4];
        assign firstBit1[4*i +: 4] = firstOfFour(leftover[4*i +: 4]);
    end

    for (genvar i = 0; i < 8; i++) begin : gLevel16
        assign hasBit16[i]         = |hasBit4[4*i +: 4];
        assign firstBit4[4*i +: 4] = firstOfFour(hasBit4[4*i +: 4]);
    end

    for (genvar i = 0; i < 2; i++) begin : gLevel64
        assign hasBit64[i]          = |hasBit16[4*i +: 4];
        assign firstBit16[4*i +: 4] = firstOfFour(hasBit16[4*i +: 4]);
    end

    // only two halves at the top
    assign firstBit64[0] = hasBit64[0];
    assign firstBit64[1] = hasBit64[1] & ~hasBit64[0];

    // a bit is the seed only if it wins at every level
    for (genvar b = 0; b < `GRAPH_WIDTH; b++) begin : gSeed
        assign seedVec[b] = firstBit1[b] & firstBit4[b/4]
                          & firstBit16[b/16] & firstBit64[b/64];
    end

    assign seedInfo.seed  = seedVec;
    assign seedInfo.empty = ~(hasBit64[0] | hasBit64[1]);

endmodule

// File: rtl/runExplorer.sv
`include "componentCount_defines.svh"

module runExplorer (
    input  graphPkg::graphVector leftover,
    input  graphPkg::graphVector linkMask,
    input  graphPkg::graphVector seed,
    output graphPkg::graphVector component,
    output graphPkg::graphVector remaining
);
    import graphPkg::*;

    // doubling steps needed to span the whole graph
    localparam int stageCount = $clog2(`GRAPH_WIDTH);

    // grow holds bits reached so far, span marks unbroken linked runs
    graphVector grow [0:stageCount];
    graphVector span [0:stageCount-1];

    // bit i can be entered from bit i-1 when set and linked below
    assign span[0] = leftover & (linkMask << 1);
    assign grow[0] = seed;

    // prefix scan in the style of a carry lookahead
    for (genvar s = 0; s < stageCount; s++) begin : gStage
        assign grow[s+1] = grow[s] | (span[s] & (grow[s] << (1 << s)));

        if (s < stageCount - 1) begin : gSpan
            assign span[s+1] = span[s] & (span[s] << (1 << s));
        end
    end

    // seed is always the lowest set bit, so flooding upward is enough
    assign component = grow[stageCount];
    assign remaining = leftover & ~grow[stageCount];

endmodule

// File: rtl/jobSequencer.sv
module jobSequencer (
    input  logic                 clk,
    input  logic                 reset,

    // job intake, four-phase
    input  logic                 jobReq,
    output logic                 jobAck,
    input  jobPkg::jobRequest    jobIn,

    input  graphPkg::seedInfo    seedInfo,
    input  graphPkg::graphVector remaining,
    input  logic                 resultBusy,

    output graphPkg::graphVector leftover,
    output graphPkg::graphVector linkMask,

    // single-cycle pulses to the result side
    output logic                 jobStart,
    output jobPkg::countValue    countBase,
    output jobPkg::jobTag        tag,
    output logic                 componentFound,
    output logic                 jobFinished
);
    import graphPkg::*;

    typedef enum logic [1:0] {
        seqIdle,
        seqExplore,
        seqRelease
    } seqState;

    seqState    state;
    logic       intake;
    logic       advance;
    graphVector nextLeftover;

    // accept only once the previous ack is gone and the result side is free
    assign intake  = (state == seqIdle) && jobReq && !jobAck && !resultBusy;
    assign advance = (state == seqExplore) && !seedInfo.empty;

    assign nextLeftover = intake ? jobIn.graph : remaining;

    always_ff @(posedge clk) begin
        if (reset) begin
            state          <= seqIdle;
            jobAck         <= 1'b0;
            jobStart       <= 1'b0;
            componentFound <= 1'b0;
            jobFinished    <= 1'b0;
        end else begin
            jobStart       <= intake;
            componentFound <= advance;
            jobFinished    <= 1'b0;

            // drop ack once the producer has released its request
            if (jobAck && !jobReq) begin
                jobAck <= 1'b0;
            end

            case (state)
                seqIdle: begin
                    if (intake) begin
                        jobAck <= 1'b1;
                        state  <= seqExplore;
                    end
                end
                seqExplore: begin
                    if (seedInfo.empty) begin
                        jobFinished <= 1'b1;
                        state       <= seqRelease;
                    end
                end
                seqRelease: begin
                    // hold until the intake handshake is fully closed
                    if (!jobAck) begin
                        state <= seqIdle;
                    end
                end
                default: state <= seqIdle;
            endcase
        end
    end

    // one component leaves the graph per cycle
    always_ff @(posedge clk) begin
        if (intake || advance) begin
            leftover <= nextLeftover;
        end
        if (intake) begin
            linkMask  <= jobIn.linkMask;
            countBase <= jobIn.countBase;
            tag       <= jobIn.tag;
        end
    end

endmodule

// File: rtl/resultPort.sv
module resultPort (
    input  logic              clk,
    input  logic              reset,

    input  logic              jobStart,
    input  jobPkg::countValue countBase,
    input  jobPkg::jobTag     tag,
    input  logic              componentFound,
    input  logic              jobFinished,

    output logic              resultBusy,

    // result channel, four-phase
    output logic              resultReq,
    input  logic              resultAck,
    output jobPkg::jobResult  resultOut
);
    import jobPkg::*;

    typedef enum logic [1:0] {
        portIdle,
        portCount,
        portWaitAck,
        portWaitRelease
    } portState;

    portState  phase;
    countValue countReg;
    jobTag     tagReg;

    always_ff @(posedge clk) begin
        if (reset) begin
            phase     <= portIdle;
            resultReq <= 1'b0;
        end else begin
            case (phase)
                portIdle: begin
                    if (jobStart) begin
                        phase <= portCount;
                    end
                end
                portCount: begin
                    if (jobFinished) begin
                        resultReq <= 1'b1;
                        phase     <= portWaitAck;
                    end
                end
                portWaitAck: begin
                    if (resultAck) begin
                        resultReq <= 1'b0;
                        phase     <= portWaitRelease;
                    end
                end
                portWaitRelease: begin
                    if (!resultAck) begin
                        phase <= portIdle;
                    end
                end
                default: phase <= portIdle;
            endcase
        end
    end

    // count wraps naturally at seven bits
    always_ff @(posedge clk) begin
        if (jobStart) begin
            countReg <= countBase;
            tagReg   <= tag;
        end else if (componentFound) begin
            countReg <= countReg + 1'b1;
        end
    end

    // busy from job start until the consumer releases its ack
    assign resultBusy      = (phase != portIdle);
    assign resultOut.count = countReg;
    assign resultOut.tag   = tagReg;

endmodule

// File: rtl/connectedCounter.sv
module connectedCounter (
    input  logic              clk,
    input  logic              reset,

    input  logic              jobReq,
    output logic              jobAck,
    input  jobPkg::jobRequest jobIn,

    output logic              resultReq,
    input  logic              resultAck,
    output jobPkg::jobResult  resultOut
);
    import graphPkg::*;
    import jobPkg::*;

    graphVector        leftover;
    graphVector        linkMask;
    graphVector        remaining;
    graphPkg::seedInfo seedInfo;

    logic      jobStart;
    logic      componentFound;
    logic      jobFinished;
    logic      resultBusy;
    countValue countBase;
    jobTag     tag;

    jobSequencer sequencer0 (
        .clk(clk), .reset(reset),
        .jobReq(jobReq), .jobAck(jobAck), .jobIn(jobIn),
        .seedInfo(seedInfo), .remaining(remaining), .resultBusy(resultBusy),
        .leftover(leftover), .linkMask(linkMask),
        .jobStart(jobStart), .countBase(countBase), .tag(tag),
        .componentFound(componentFound), .jobFinished(jobFinished)
    );

    // decode, lowest set bit of what is left
    seedSelector selector0 (.leftover(leftover), .seedInfo(seedInfo));

    // execute, flood the seed and strip its component
    runExplorer explorer0 (
        .leftover(leftover), .linkMask(linkMask), .seed(seedInfo.seed),
        .component(), .remaining(remaining)
    );

    resultPort result0 (
        .clk(clk), .reset(reset),
        .jobStart(jobStart), .countBase(countBase), .tag(tag),
        .componentFound(componentFound), .jobFinished(jobFinished),
        .resultBusy(resultBusy),
        .resultReq(resultReq), .resultAck(resultAck), .resultOut(resultOut)
    );

endmodule

// File: tests/connectedCounterTb.sv
`include "componentCount_defines.svh"

module connectedCounterTb;
    import graphPkg::*;
    import jobPkg::*;

    localparam int resetCycles = 8;
    localparam int idleCycles  = 10;
    localparam int randomJobs  = 200;
    localparam int totalJobs   = 4 + randomJobs + 2;
    localparam int waitLimit   = 1000;
    localparam logic [31:0] lfsrSeed = 32'h25cb_a9a8;

    logic      clk = 1'b0;
    logic      reset;
    logic      jobReq;
    logic      jobAck;
    jobRequest jobIn;
    logic      resultReq;
    logic      resultAck;
    jobResult  resultOut;

    // predicted results in job order
    jobResult    expectedQ[$];
    int          resultsChecked;
    logic [31:0] stimLfsr;
    logic [31:0] ackLfsr;

    // handshake monitor, values of the cycle before each rising edge
    logic     seenJobReq;
    logic     seenJobAck;
    logic     seenResultReq;
    logic     seenResultAck;
    jobResult seenResultOut;
    int       openResults;

    connectedCounter dut0 (
        .clk(clk), .reset(reset),
        .jobReq(jobReq), .jobAck(jobAck), .jobIn(jobIn),
        .resultReq(resultReq), .resultAck(resultAck), .resultOut(resultOut)
    );

    always #2 clk = ~clk;

    task automatic abortRun();
        $display("sim failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic reportFailure(input string why);
        $display("%s at time %0t", why, $time);
        abortRun();
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch at time %0t: %s expected %0h got %0h",
                     $time, name, expected, actual);
            abortRun();
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // one step per bit, newest bit lands in the LSB
    task automatic takeBits(input int count, inout logic [31:0] state,
                            output logic [127:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            state = lfsrNext(state);
            bits  = {bits[126:0], state[0]};
        end
    endtask

    // a set bit starts a new component unless its linked neighbour below is set
    function automatic jobResult referenceResult(input jobRequest job);
        jobResult  expected;
        countValue count;
        logic      joined;
        count = job.countBase;
        for (int i = 0; i < `GRAPH_WIDTH; i++) begin
            joined = 1'b0;
            if (i > 0) begin
                joined = job.graph[i-1] & job.linkMask[i-1];
            end
            if (job.graph[i] && !joined) begin
                count = count + 7'd1;
            end
        end
        expected.count = count;
        expected.tag   = job.tag;
        return expected;
    endfunction

    task automatic awaitJobAck(input logic level);
        int waited;
        waited = 0;
        while (jobAck !== level) begin
            @(negedge clk);
            waited++;
            if (waited > waitLimit) begin
                reportFailure($sformatf("timeout waiting for jobAck to become %0b", level));
            end
        end
    endtask

    task automatic awaitResultReq(input logic level);
        int waited;
        waited = 0;
        while (resultReq !== level) begin
            @(negedge clk);
            waited++;
            if (waited > waitLimit) begin
                reportFailure($sformatf("timeout waiting for resultReq to become %0b", level));
            end
        end
    endtask

    task automatic sendJob(input jobRequest job);
        @(negedge clk);
        jobIn  = job;
        jobReq = 1'b1;
        expectedQ.push_back(referenceResult(job));
        awaitJobAck(1'b1);
        jobReq = 1'b0;
        // scrambled inputs must not reach the running job
        jobIn.graph     = ~job.graph;
        jobIn.linkMask  = ~job.linkMask;
        jobIn.countBase = ~job.countBase;
        jobIn.tag       = ~job.tag;
        awaitJobAck(1'b0);
    endtask

    // directed cases also pin the reference to hand-computed counts
    task automatic sendDirected(input jobRequest job, input countValue expectedCount);
        jobResult predicted;
        predicted = referenceResult(job);
        checkValue("reference count", 32'(expectedCount), 32'(predicted.count));
        sendJob(job);
    endtask

    task automatic randomJob(output jobRequest job);
        logic [127:0] bits;
        takeBits(128, stimLfsr, bits);
        job.graph = bits;
        takeBits(128, stimLfsr, bits);
        job.linkMask = bits;
        takeBits(7, stimLfsr, bits);
        job.countBase = bits[6:0];
        takeBits(8, stimLfsr, bits);
        job.tag = bits[7:0];
    endtask

    always @(posedge clk) begin
        if (reset) begin
            seenJobReq    = 1'b0;
            seenJobAck    = 1'b0;
            seenResultReq = 1'b0;
            seenResultAck = 1'b0;
            openResults   = 0;
        end else begin
            if (seenJobAck && !jobAck && seenJobReq) begin
                reportFailure("jobAck fell while jobReq was still high");
            end
            // a result is closed once its ack has fallen
            if (seenResultAck && !resultAck) begin
                openResults--;
            end
            if (!seenJobAck && jobAck) begin
                if (openResults != 0) begin
                    reportFailure("jobAck rose while an earlier result was still open");
                end
                openResults++;
            end
            if (seenResultReq && resultReq) begin
                checkValue("resultOut", 32'(seenResultOut), 32'(resultOut));
            end
            if (seenResultReq && !resultReq && !seenResultAck) begin
                reportFailure("resultReq fell before resultAck was raised");
            end
            seenJobReq    = jobReq;
            seenJobAck    = jobAck;
            seenResultReq = resultReq;
            seenResultAck = resultAck;
            seenResultOut = resultOut;
        end
    end

    // consumer side, compares every result against the reference
    initial begin : resultChecker
        jobResult     expected;
        logic [127:0] bits;
        resultAck      = 1'b0;
        resultsChecked = 0;
        ackLfsr        = lfsrSeed;
        repeat (resetCycles) @(negedge clk);
        for (int k = 0; k < totalJobs; k++) begin
            awaitResultReq(1'b1);
            if (expectedQ.size() == 0) begin
                reportFailure("result arrived with no job outstanding");
            end
            expected = expectedQ.pop_front();
            checkValue("resultOut.count", 32'(expected.count), 32'(resultOut.count));
            checkValue("resultOut.tag", 32'(expected.tag), 32'(resultOut.tag));
            // the last pair holds the ack back longer
            takeBits((k >= totalJobs - 2) ? 5 : 3, ackLfsr, bits);
            repeat (bits[4:0]) @(negedge clk);
            resultAck = 1'b1;
            awaitResultReq(1'b0);
            takeBits(2, ackLfsr, bits);
            repeat (bits[1:0]) @(negedge clk);
            resultAck = 1'b0;
            resultsChecked++;
        end
    end

    initial begin : stimulus
        jobRequest job;
        int        waited;
        reset    = 1'b1;
        jobReq   = 1'b0;
        jobIn    = '0;
        stimLfsr = lfsrSeed;
        repeat (resetCycles) @(negedge clk);
        reset = 1'b0;

        // nothing moves without a job
        repeat (idleCycles) begin
            @(negedge clk);
            checkValue("jobAck", 32'd0, 32'(jobAck));
            checkValue("resultReq", 32'd0, 32'(resultReq));
        end

        job.linkMask  = '1;
        job.graph     = '0;
        job.countBase = 7'd17;
        job.tag       = 8'h11;
        sendDirected(job, 7'd17);
        job.graph     = '1;
        job.countBase = 7'd127;
        job.tag       = 8'h22;
        sendDirected(job, 7'd0);
        job.graph     = {64{2'b01}};
        job.countBase = 7'd5;
        job.tag       = 8'h33;
        sendDirected(job, 7'd69);
        job.graph     = '1;
        job.linkMask  = '0;
        job.countBase = 7'd42;
        job.tag       = 8'h44;
        sendDirected(job, 7'd42);

        for (int n = 0; n < randomJobs; n++) begin
            randomJob(job);
            sendJob(job);
        end

        // back-to-back pair while the consumer withholds its ack
        randomJob(job);
        sendJob(job);
        randomJob(job);
        sendJob(job);

        waited = 0;
        while (resultsChecked < totalJobs) begin
            @(negedge clk);
            waited++;
            if (waited > waitLimit) begin
                reportFailure("timeout waiting for the last results");
            end
        end
        $display("sim passed");
        $finish;
    end

endmodule

// File: verilog.f
+incdir+rtl
rtl/graphPkg.sv
rtl/jobPkg.sv
rtl/seedSelector.sv
rtl/runExplorer.sv
rtl/jobSequencer.sv
rtl/resultPort.sv
rtl/connectedCounter.sv
tests/connectedCounterTb.sv

// File: Makefile
TOP       ?= connectedCounterTb
FILELIST  ?= verilog.f
BUILD_DIR ?= build
LOG       ?= sim.log
VERILATOR ?= verilator

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "sim passed" $(LOG) || (echo "simulation did not pass, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
